/* sources.f */
+incdir+include
src/decodePkg.sv
src/instrFetch.sv
src/instrQueue.sv
src/regFileBypass.sv
src/instrDecode.sv
src/decodeTop.sv
tests/decodeTb.sv

/* Bender.yml */
package:
  name: instr_decode

sources:
  - files:
      - src/decodePkg.sv
      - src/instrFetch.sv
      - src/instrQueue.sv
      - src/regFileBypass.sv
      - src/instrDecode.sv
      - src/decodeTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/decodeTb.sv

/* include/tbUtil.svh */
// Include inside a module; one shared LFSR stream, takeBits returns at most 16 bits per call
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// Galois LFSR state, stepped once per random bit
logic [15:0] lfsrState = 16'd58;

// Failed and total field comparisons
int errCount   = 0;
int checkCount = 0;

// Taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] galoisStep(input logic [15:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
endfunction

// Collects count bits, lowest first
function automatic logic [15:0] takeBits(input int count);
    logic [15:0] bits;
    bits = '0;
    for (int k = 0; k < count; k++) begin
        lfsrState = galoisStep(lfsrState);
        bits[k]   = lfsrState[0];
    end
    return bits;
endfunction

// One comparison of a DUT field against the model
task automatic checkField(
    input string       name,
    input logic [15:0] got,
    input logic [15:0] expected
);
    checkCount++;
    if (got !== expected) begin
        errCount++;
        $display("Fail at %0t: %s is %h, model has %h", $time, name, got, expected);
    end
endtask

`endif

/* tests/decodeTb.sv */
// Memory model holds 256 words and wraps; rs and rt data are expected with same-edge write bypass
`timescale 1ns/100ps

module decodeTb;

    `include "tbUtil.svh"

    localparam int numInstr   = 200;
    localparam int cycleLimit = numInstr * 8 + 100;

    logic        clk;
    logic        rst;
    logic        wbCyc;
    logic        wbStb;
    logic [15:0] wbAdr;
    logic [15:0] wbDatIn;
    logic        wbAck;
    logic        stall;
    logic        wbEn;
    logic [2:0]  wbSel;
    logic [15:0] wbData;
    logic        outValid;
    logic [15:0] rsData;
    logic [15:0] rtData;
    logic [15:0] imm;
    logic [1:0]  aluOp;
    logic        immSrc;
    logic [2:0]  rd;
    logic        regWrt;
    logic        memRead;
    logic        memWrt;
    logic        halt;
    logic        err;

    logic [15:0] imem [256];

    // Register model plus its state and write-back as seen at the last edge
    logic [15:0] modelRegs [8];
    logic [15:0] popRegs [8];
    logic        popWbEn;
    logic [2:0]  popWbSel;
    logic [15:0] popWbData;

    // Slave side of the current bus cycle
    logic        pending;
    int          waitLeft;
    logic [15:0] heldAdr;
    logic [15:0] fetchAdr;

    int   doneCount;
    int   cycles;
    logic seenOut;

    // Expected decode of one word
    logic [1:0]  expAlu;
    logic [15:0] expImm;
    logic [2:0]  expRd;
    logic        expImmSrc;
    logic        expRegWrt;
    logic        expMemRead;
    logic        expMemWrt;
    logic        expHalt;
    logic        expErr;

    decodeTop i_decodeTop (
        .clk      (clk),
        .rst      (rst),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbAdr    (wbAdr),
        .wbDatIn  (wbDatIn),
        .wbAck    (wbAck),
        .stall    (stall),
        .wbEn     (wbEn),
        .wbSel    (wbSel),
        .wbData   (wbData),
        .outValid (outValid),
        .rsData   (rsData),
        .rtData   (rtData),
        .imm      (imm),
        .aluOp    (aluOp),
        .immSrc   (immSrc),
        .rd       (rd),
        .regWrt   (regWrt),
        .memRead  (memRead),
        .memWrt   (memWrt),
        .halt     (halt),
        .err      (err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic isLegal(input logic [4:0] op);
        case (op)
            decodePkg::opAddi, decodePkg::opSubi, decodePkg::opXori, decodePkg::opAndni,
            decodePkg::opLd, decodePkg::opSt, decodePkg::opAlu, decodePkg::opNop,
            decodePkg::opHalt: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [4:0] legalByIndex(input int idx);
        case (idx)
            0: return decodePkg::opAddi;
            1: return decodePkg::opSubi;
            2: return decodePkg::opXori;
            3: return decodePkg::opAndni;
            4: return decodePkg::opLd;
            5: return decodePkg::opSt;
            6: return decodePkg::opAlu;
            7: return decodePkg::opNop;
            default: return decodePkg::opHalt;
        endcase
    endfunction

    // One word in eight gets an opcode outside the ISA
    function automatic logic [4:0] pickOpcode();
        logic [15:0] bits;
        logic [4:0]  op;
        if (takeBits(3) == 16'd0) begin
            do begin
                bits = takeBits(5);
                op   = bits[4:0];
            end while (isLegal(op));
        end else begin
            op = legalByIndex(takeBits(4) % 9);
        end
        return op;
    endfunction

    task automatic fillMemory();
        logic [4:0]  op;
        logic [15:0] rest;
        for (int a = 0; a < 256; a++) begin
            op      = pickOpcode();
            rest    = takeBits(11);
            imem[a] = {op, rest[10:0]};
        end
    endtask

    // Register value seen by a read at the last edge
    function automatic logic [15:0] readModel(input logic [2:0] sel);
        if (popWbEn && popWbSel == sel) begin
            return popWbData;
        end
        return popRegs[sel];
    endfunction

    task automatic decodeRef(input logic [15:0] w);
        logic [4:0]  op;
        logic [15:0] sExt;
        logic [15:0] zExt;
        op         = w[15:11];
        sExt       = {{11{w[4]}}, w[4:0]};
        zExt       = {11'd0, w[4:0]};
        expAlu     = 2'd0;
        expImm     = 16'd0;
        expRd      = 3'd0;
        expImmSrc  = 1'b0;
        expRegWrt  = 1'b0;
        expMemRead = 1'b0;
        expMemWrt  = 1'b0;
        expHalt    = 1'b0;
        expErr     = 1'b0;
        case (op)
            decodePkg::opAddi, decodePkg::opSubi, decodePkg::opXori, decodePkg::opAndni,
            decodePkg::opLd, decodePkg::opSt: begin
                expImmSrc  = 1'b1;
                expImm     = (op == decodePkg::opXori || op == decodePkg::opAndni) ? zExt : sExt;
                expAlu     = (op == decodePkg::opSubi)  ? decodePkg::aluSub :
                             (op == decodePkg::opXori)  ? decodePkg::aluXor :
                             (op == decodePkg::opAndni) ? decodePkg::aluAndn : decodePkg::aluAdd;
                expRd      = (op == decodePkg::opSt) ? 3'd0 : w[7:5];
                expRegWrt  = (op != decodePkg::opSt);
                expMemRead = (op == decodePkg::opLd);
                expMemWrt  = (op == decodePkg::opSt);
            end
            decodePkg::opAlu: begin
                expAlu    = w[1:0];
                expRd     = w[4:2];
                expRegWrt = 1'b1;
            end
            decodePkg::opNop: ;
            decodePkg::opHalt: expHalt = 1'b1;
            default: expErr = 1'b1;
        endcase
    endtask

    task automatic checkIdle();
        checkField("regWrt", regWrt, 16'd0);
        checkField("memRead", memRead, 16'd0);
        checkField("memWrt", memWrt, 16'd0);
        checkField("halt", halt, 16'd0);
        checkField("err", err, 16'd0);
    endtask

    task automatic checkDecoded();
        logic [15:0] w;
        string       tag;
        if (outValid) begin
            w   = imem[doneCount % 256];
            tag = $sformatf("instr %0d ", doneCount);
            decodeRef(w);
            checkField({tag, "rsData"}, rsData, readModel(w[10:8]));
            checkField({tag, "rtData"}, rtData, readModel(w[7:5]));
            checkField({tag, "imm"}, imm, expImm);
            checkField({tag, "aluOp"}, aluOp, expAlu);
            checkField({tag, "immSrc"}, immSrc, expImmSrc);
            checkField({tag, "rd"}, rd, expRd);
            checkField({tag, "regWrt"}, regWrt, expRegWrt);
            checkField({tag, "memRead"}, memRead, expMemRead);
            checkField({tag, "memWrt"}, memWrt, expMemWrt);
            checkField({tag, "halt"}, halt, expHalt);
            checkField({tag, "err"}, err, expErr);
            doneCount++;
            seenOut = 1'b1;
        end else if (!seenOut) begin
            checkIdle();
        end
    endtask

    // Wishbone slave with 0 to 3 wait states per read
    task automatic serveBus();
        if (pending) begin
            checkField("wbCyc held", wbCyc, 16'd1);
            checkField("wbStb held", wbStb, 16'd1);
            checkField("wbAdr held", wbAdr, heldAdr);
        end
        wbAck = 1'b0;
        if (wbStb) begin
            if (!pending) begin
                checkField("wbCyc", wbCyc, 16'd1);
                checkField("wbAdr", wbAdr, fetchAdr);
                pending  = 1'b1;
                heldAdr  = wbAdr;
                waitLeft = takeBits(2);
            end
            if (waitLeft == 0) begin
                wbAck    = 1'b1;
                wbDatIn  = imem[wbAdr[7:0]];
                pending  = 1'b0;
                fetchAdr = fetchAdr + 16'd1;
            end else begin
                waitLeft--;
            end
        end
    endtask

    task automatic driveStimulus();
        logic [15:0] bits;
        stall  = (takeBits(2) == 16'd0);
        bits   = takeBits(1);
        wbEn   = bits[0];
        bits   = takeBits(3);
        wbSel  = bits[2:0];
        wbData = takeBits(16);
    endtask

    // Model register file written on the same edge as the DUT
    always @(posedge clk) begin
        for (int k = 0; k < 8; k++) begin
            popRegs[k] = modelRegs[k];
        end
        popWbEn   = wbEn;
        popWbSel  = wbSel;
        popWbData = wbData;
        if (rst) begin
            for (int k = 0; k < 8; k++) begin
                modelRegs[k] = 16'd0;
            end
        end else if (wbEn) begin
            modelRegs[wbSel] = wbData;
        end
    end

    initial begin
        rst       = 1'b1;
        stall     = 1'b0;
        wbEn      = 1'b0;
        wbSel     = 3'd0;
        wbData    = 16'd0;
        wbAck     = 1'b0;
        wbDatIn   = 16'd0;
        pending   = 1'b0;
        waitLeft  = 0;
        heldAdr   = 16'd0;
        fetchAdr  = 16'd0;
        doneCount = 0;
        cycles    = 0;
        seenOut   = 1'b0;
        fillMemory();
        repeat (16) begin
            @(negedge clk);
            checkField("wbCyc", wbCyc, 16'd0);
            checkField("outValid", outValid, 16'd0);
            checkIdle();
        end
        rst = 1'b0;
        while (doneCount < numInstr && cycles < cycleLimit) begin
            @(negedge clk);
            cycles++;
            checkDecoded();
            serveBus();
            driveStimulus();
        end
        if (doneCount < numInstr) begin
            $display("Timeout: the decoder stopped producing instructions after %0d of %0d",
                     doneCount, numInstr);
            errCount++;
        end
        $display("Errors: %0d in %0d checks over %0d instructions",
                 errCount, checkCount, doneCount);
        if (errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* src/decodeTop.sv */
// Fetch, queue and decode chained in order; halt is reported only and does not stop fetch
`timescale 1ns/100ps

module decodeTop (
    input  logic                              clk,
    input  logic                              rst,
    output logic                              wbCyc,
    output logic                              wbStb,
    output logic [decodePkg::wordWidth-1:0]   wbAdr,
    input  logic [decodePkg::wordWidth-1:0]   wbDatIn,
    input  logic                              wbAck,
    input  logic                              stall,
    input  logic                              wbEn,
    input  logic [decodePkg::regSelWidth-1:0] wbSel,
    input  logic [decodePkg::wordWidth-1:0]   wbData,
    output logic                              outValid,
    output logic [decodePkg::wordWidth-1:0]   rsData,
    output logic [decodePkg::wordWidth-1:0]   rtData,
    output logic [decodePkg::wordWidth-1:0]   imm,
    output logic [decodePkg::aluOpWidth-1:0]  aluOp,
    output logic                              immSrc,
    output logic [decodePkg::regSelWidth-1:0] rd,
    output logic                              regWrt,
    output logic                              memRead,
    output logic                              memWrt,
    output logic                              halt,
    output logic                              err
);

    logic                pushValid;
    decodePkg::instrWord pushData;
    logic                full;
    logic                notEmpty;
    decodePkg::instrWord headData;
    logic                pop;

    instrFetch i_instrFetch (
        .clk       (clk),
        .rst       (rst),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbAdr     (wbAdr),
        .wbDatIn   (wbDatIn),
        .wbAck     (wbAck),
        .full      (full),
        .pushValid (pushValid),
        .pushData  (pushData)
    );

    instrQueue i_instrQueue (
        .clk       (clk),
        .rst       (rst),
        .pushValid (pushValid),
        .pushData  (pushData),
        .full      (full),
        .pop       (pop),
        .notEmpty  (notEmpty),
        .headData  (headData)
    );

    instrDecode i_instrDecode (
        .clk      (clk),
        .rst      (rst),
        .notEmpty (notEmpty),
        .headData (headData),
        .pop      (pop),
        .stall    (stall),
        .wbEn     (wbEn),
        .wbSel    (wbSel),
        .wbData   (wbData),
        .outValid (outValid),
        .rsData   (rsData),
        .rtData   (rtData),
        .imm      (imm),
        .aluOp    (aluOp),
        .immSrc   (immSrc),
        .rd       (rd),
        .regWrt   (regWrt),
        .memRead  (memRead),
        .memWrt   (memWrt),
        .halt     (halt),
        .err      (err)
    );

endmodule

/* src/instrDecode.sv */
// Decodes one queued word per unstalled cycle; data fields are valid only with outValid
`timescale 1ns/100ps

module instrDecode (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              notEmpty,
    input  decodePkg::instrWord               headData,
    output logic                              pop,
    input  logic                              stall,
    input  logic                              wbEn,
    input  logic [decodePkg::regSelWidth-1:0] wbSel,
    input  logic [decodePkg::wordWidth-1:0]   wbData,
    output logic                              outValid,
    output logic [decodePkg::wordWidth-1:0]   rsData,
    output logic [decodePkg::wordWidth-1:0]   rtData,
    output logic [decodePkg::wordWidth-1:0]   imm,
    output logic [decodePkg::aluOpWidth-1:0]  aluOp,
    output logic                              immSrc,
    output logic [decodePkg::regSelWidth-1:0] rd,
    output logic                              regWrt,
    output logic                              memRead,
    output logic                              memWrt,
    output logic                              halt,
    output logic                              err
);

    logic [decodePkg::wordWidth-1:0]   rsRead;
    logic [decodePkg::wordWidth-1:0]   rtRead;
    logic [decodePkg::wordWidth-1:0]   sExtImm;
    logic [decodePkg::wordWidth-1:0]   zExtImm;
    logic [decodePkg::wordWidth-1:0]   nextImm;
    logic [decodePkg::aluOpWidth-1:0]  nextAluOp;
    logic [decodePkg::regSelWidth-1:0] nextRd;
    logic nextImmSrc;
    logic nextRegWrt;
    logic nextMemRead;
    logic nextMemWrt;
    logic nextHalt;
    logic nextErr;

    assign pop = notEmpty && !stall;

    // rs and rt always come from the R-format positions
    regFileBypass i_regFileBypass (
        .clk       (clk),
        .rst       (rst),
        .readSelA  (headData.r.rs),
        .readSelB  (headData.r.rt),
        .readDataA (rsRead),
        .readDataB (rtRead),
        .writeEn   (wbEn),
        .writeSel  (wbSel),
        .writeData (wbData)
    );

    assign sExtImm = {
        {(decodePkg::wordWidth - decodePkg::immWidth){headData.i.imm5[decodePkg::immWidth-1]}},
        headData.i.imm5
    };
    assign zExtImm = {{(decodePkg::wordWidth - decodePkg::immWidth){1'b0}}, headData.i.imm5};

    // Control decode, every field not listed for an opcode stays zero
    always_comb begin
        nextAluOp   = '0;
        nextImm     = '0;
        nextRd      = '0;
        nextImmSrc  = 1'b0;
        nextRegWrt  = 1'b0;
        nextMemRead = 1'b0;
        nextMemWrt  = 1'b0;
        nextHalt    = 1'b0;
        nextErr     = 1'b0;
        case (headData.i.opcode)
            decodePkg::opAddi, decodePkg::opSubi, decodePkg::opLd: begin
                nextAluOp  = (headData.i.opcode == decodePkg::opSubi) ?
                             decodePkg::aluSub : decodePkg::aluAdd;
                nextImm     = sExtImm;
                nextRd      = headData.i.rd;
                nextImmSrc  = 1'b1;
                nextRegWrt  = 1'b1;
                nextMemRead = (headData.i.opcode == decodePkg::opLd);
            end
            decodePkg::opXori, decodePkg::opAndni: begin
                nextAluOp  = (headData.i.opcode == decodePkg::opXori) ?
                             decodePkg::aluXor : decodePkg::aluAndn;
                nextImm    = zExtImm;
                nextRd     = headData.i.rd;
                nextImmSrc = 1'b1;
                nextRegWrt = 1'b1;
            end
            // Store has no destination
            decodePkg::opSt: begin
                nextAluOp  = decodePkg::aluAdd;
                nextImm    = sExtImm;
                nextImmSrc = 1'b1;
                nextMemWrt = 1'b1;
            end
            decodePkg::opAlu: begin
                nextAluOp  = headData.r.funct;
                nextRd     = headData.r.rd;
                nextRegWrt = 1'b1;
            end
            decodePkg::opNop: ;
            decodePkg::opHalt: nextHalt = 1'b1;
            default: nextErr = 1'b1;
        endcase
    end

    // Flags hold between pops
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            regWrt   <= 1'b0;
            memRead  <= 1'b0;
            memWrt   <= 1'b0;
            halt     <= 1'b0;
            err      <= 1'b0;
        end else begin
            outValid <= pop;
            if (pop) begin
                regWrt  <= nextRegWrt;
                memRead <= nextMemRead;
                memWrt  <= nextMemWrt;
                halt    <= nextHalt;
                err     <= nextErr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rsData <= rsRead;
            rtData <= rtRead;
            imm    <= nextImm;
            aluOp  <= nextAluOp;
            immSrc <= nextImmSrc;
            rd     <= nextRd;
        end
    end

    // A stalled cycle never yields an instruction one clock later
    noOutAfterStall: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> !outValid
    ) else $error("outValid high in the cycle after stall");

endmodule

/* src/regFileBypass.sv */
// Eight registers including r0 which is writable; reads are combinational with write bypass
`timescale 1ns/100ps

module regFileBypass (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [decodePkg::regSelWidth-1:0] readSelA,
    input  logic [decodePkg::regSelWidth-1:0] readSelB,
    output logic [decodePkg::wordWidth-1:0]   readDataA,
    output logic [decodePkg::wordWidth-1:0]   readDataB,
    input  logic                              writeEn,
    input  logic [decodePkg::regSelWidth-1:0] writeSel,
    input  logic [decodePkg::wordWidth-1:0]   writeData
);

    logic [decodePkg::wordWidth-1:0] regs [2**decodePkg::regSelWidth];

    logic hitA;
    logic hitB;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 2**decodePkg::regSelWidth; k++) begin
                regs[k] <= '0;
            end
        end else if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    // Same-cycle write wins over the stored value
    assign hitA = writeEn && (writeSel == readSelA);
    assign hitB = writeEn && (writeSel == readSelB);

    assign readDataA = hitA ? writeData : regs[readSelA];
    assign readDataB = hitB ? writeData : regs[readSelB];

endmodule

/* src/instrQueue.sv */
// First-word fall-through FIFO; caller must not push when full or pop when empty
`timescale 1ns/100ps

module instrQueue (
    input  logic                clk,
    input  logic                rst,
    input  logic                pushValid,
    input  decodePkg::instrWord pushData,
    output logic                full,
    input  logic                pop,
    output logic                notEmpty,
    output decodePkg::instrWord headData
);

    logic [decodePkg::queuePtrWidth-1:0] wrPtr;
    logic [decodePkg::queuePtrWidth-1:0] rdPtr;
    // One bit wider than the pointers so full and empty differ
    logic [decodePkg::queuePtrWidth:0]   count;

    decodePkg::instrWord mem [decodePkg::queueDepth];

    // Storage
    always_ff @(posedge clk) begin
        if (pushValid) begin
            mem[wrPtr] <= pushData;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({pushValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Top count bit is set only at exactly queueDepth entries
    assign full     = count[decodePkg::queuePtrWidth];
    assign notEmpty = |count;
    assign headData = mem[rdPtr];

    // Fetch reserves its slot before the bus cycle starts
    noPushWhenFull: assert property (
        @(posedge clk) disable iff (rst)
        pushValid |-> !full
    ) else $error("Push into a full instruction queue");

    // Decode only pops a valid head
    noPopWhenEmpty: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> notEmpty
    ) else $error("Pop from an empty instruction queue");

endmodule

/* src/instrFetch.sv */
// Read-only Wishbone classic master, one outstanding word, address wraps after 0xFFFF
`timescale 1ns/100ps

module instrFetch (
    input  logic                            clk,
    input  logic                            rst,
    output logic                            wbCyc,
    output logic                            wbStb,
    output logic [decodePkg::wordWidth-1:0] wbAdr,
    input  logic [decodePkg::wordWidth-1:0] wbDatIn,
    input  logic                            wbAck,
    input  logic                            full,
    output logic                            pushValid,
    output decodePkg::instrWord             pushData
);

    // Bus cycle in progress
    logic busy;
    // Word address of the next instruction
    logic [decodePkg::wordWidth-1:0] pc;

    // A request is only started with a free queue slot, and since fetch is the
    // sole writer of the queue that slot stays reserved until the ack
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            pc   <= '0;
        end else if (busy) begin
            if (wbAck) begin
                busy <= 1'b0;
                pc   <= pc + 1'b1;
            end
        end else if (!full) begin
            busy <= 1'b1;
        end
    end

    assign wbCyc = busy;
    assign wbStb = busy;
    assign wbAdr = pc;

    // Word goes into the queue in the ack cycle itself
    assign pushValid = busy & wbAck;
    assign pushData  = wbDatIn;

    // Request must not move while the slave inserts wait states
    adrHeldUntilAck: assert property (
        @(posedge clk) disable iff (rst)
        (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr))
    ) else $error("wbStb or wbAdr changed before wbAck");

endmodule

/* src/decodePkg.sv */
// ISA opcode map and instruction formats; queueDepth must stay a power of two
package decodePkg;

    // Data path and field widths
    localparam int wordWidth   = 16;
    localparam int regSelWidth = 3;
    localparam int opcodeWidth = 5;
    localparam int immWidth    = 5;
    localparam int aluOpWidth  = 2;

    // Instruction queue
    localparam int queueDepth    = 4;
    localparam int queuePtrWidth = $clog2(queueDepth);

    // I-format ALU operations with a 5-bit immediate
    localparam logic [opcodeWidth-1:0] opAddi  = 5'b01000;
    localparam logic [opcodeWidth-1:0] opSubi  = 5'b01001;
    localparam logic [opcodeWidth-1:0] opXori  = 5'b01010;
    localparam logic [opcodeWidth-1:0] opAndni = 5'b01011;

    // Memory access, address is rs plus the immediate
    localparam logic [opcodeWidth-1:0] opSt = 5'b10000;
    localparam logic [opcodeWidth-1:0] opLd = 5'b10001;

    // R-format ALU, the operation comes from funct
    localparam logic [opcodeWidth-1:0] opAlu = 5'b11011;

    localparam logic [opcodeWidth-1:0] opNop  = 5'b00001;
    localparam logic [opcodeWidth-1:0] opHalt = 5'b00000;

    // ALU operation select, also the R-format funct encoding
    localparam logic [aluOpWidth-1:0] aluAdd  = 2'b00;
    localparam logic [aluOpWidth-1:0] aluSub  = 2'b01;
    localparam logic [aluOpWidth-1:0] aluXor  = 2'b10;
    localparam logic [aluOpWidth-1:0] aluAndn = 2'b11;

    // Register-register layout
    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [regSelWidth-1:0] rs;
        logic [regSelWidth-1:0] rt;
        logic [regSelWidth-1:0] rd;
        logic [aluOpWidth-1:0]  funct;
    } rFormat;

    // Register-immediate layout
    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [regSelWidth-1:0] rs;
        logic [regSelWidth-1:0] rd;
        logic [immWidth-1:0]    imm5;
    } iFormat;

    // Same 16-bit word seen in either format
    typedef union packed {
        rFormat r;
        iFormat i;
    } instrWord;

endpackage
